//--- Bender.yml
package:
  name: spi_mem_ctl

export_include_dirs:
  - common

sources:
  - files:
      - common/spi_mem_pkg.sv
      - logic/load_store_format.sv
      - spi_master/spi_master.sv
      - mem_ctl/access_sequencer.sv
      - mem_ctl/spi_mem_ctl.sv
  - target: test
    files:
      - testbench/clk_gen.sv
      - testbench/spi_mem_model.sv
      - testbench/tb_spi_mem_ctl.sv

//--- common/spi_mem_config.svh
/*
 * SPI memory controller configuration
 * Address map, serial address width, SPI command codes and GPIO width
 */
`ifndef SPI_MEM_CONFIG_SVH
`define SPI_MEM_CONFIG_SVH

// Serial memory address width
`define SPI_ADDR_W 24

// Region select on address bits 31:24
`define FLASH_REGION 8'h00
`define PSRAM_REGION 8'h01

// GPIO page on address bits 31:8
`define GPIO_PAGE 24'h020000
`define GPIO_W 8

// Single-lane SPI commands
`define SPI_CMD_READ 8'h03
`define SPI_CMD_WRITE 8'h02

// Sequential fetch step in bytes
`define INSTR_STEP 4

`endif

//--- common/spi_mem_pkg.sv
/*
 * SPI memory controller types
 * Vector typedefs, state enums and the request/response structs
 * exchanged between the access sequencer and the SPI engine
 */
`include "spi_mem_config.svh"

package spi_mem_pkg;

    typedef logic [31:0] word_t;
    typedef logic [`SPI_ADDR_W-1:0] spi_addr_t;
    typedef logic [5:0] xfer_len_t;
    typedef logic [2:0] mem_flag_t;
    typedef logic [`GPIO_W-1:0] gpio_t;

    typedef enum logic {CHIP_FLASH, CHIP_PSRAM} chip_sel_t;

    typedef enum logic [2:0] {
        ACC_IDLE,
        ACC_ACTIVE,
        ACC_NEXT_INSTR,
        ACC_PAUSE,
        ACC_STOP
    } access_state_t;

    typedef enum logic [2:0] {PH_IDLE, PH_CMD, PH_ADDR, PH_DATA, PH_HOLD} spi_phase_t;

    typedef struct packed {
        logic      start;
        logic      stop;
        logic      cont;
        logic      write;
        chip_sel_t chip;
        spi_addr_t addr;
        xfer_len_t len;
        word_t     wdata;
    } spi_req_t;

    typedef struct packed {
        logic  done;
        word_t rdata;
    } spi_rsp_t;

endpackage

//--- logic/load_store_format.sv
/*
 * Load/store formatter
 * Converts between little-endian core words and the wire stream,
 * which carries the lowest address byte first, MSB first
 */
`timescale 1ns/100ps

module load_store_format (
    input  spi_mem_pkg::word_t     mem_wdata,
    input  spi_mem_pkg::mem_flag_t mem_flag,
    input  spi_mem_pkg::word_t     wire_rdata,
    output spi_mem_pkg::word_t     store_word,
    output spi_mem_pkg::xfer_len_t store_len,
    output spi_mem_pkg::word_t     load_word,
    output spi_mem_pkg::word_t     instr_word
);

    function automatic spi_mem_pkg::word_t swap_bytes(spi_mem_pkg::word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign instr_word = swap_bytes(wire_rdata);

    // Stores are left-aligned, loads arrive right-aligned and zero-extended
    always_comb begin
        case (mem_flag[1:0])
            2'b00: begin
                store_word = {mem_wdata[7:0], 24'h0};
                store_len = 6'd8;
                load_word = {24'h0, wire_rdata[7:0]};
            end
            2'b01: begin
                store_word = {mem_wdata[7:0], mem_wdata[15:8], 16'h0};
                store_len = 6'd16;
                load_word = {16'h0, wire_rdata[7:0], wire_rdata[15:8]};
            end
            default: begin
                store_word = swap_bytes(mem_wdata);
                store_len = 6'd32;
                load_word = swap_bytes(wire_rdata);
            end
        endcase
    end

endmodule

//--- mem_ctl/access_sequencer.sv
/*
 * Access sequencer
 * Decodes GPIO, flash and PSRAM requests, gives data priority over
 * fetch, keeps the fetch burst open to prefetch the next word and
 * holds the GPIO output register
 */
`timescale 1ns/100ps
`include "spi_mem_config.svh"

module access_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  spi_mem_pkg::word_t     instr_addr,
    input  spi_mem_pkg::word_t     mem_addr,
    input  spi_mem_pkg::word_t     mem_wdata,
    input  spi_mem_pkg::mem_flag_t mem_flag,
    input  logic                   mem_we,
    input  logic                   mem_re,
    input  spi_mem_pkg::spi_rsp_t  spi_rsp,
    input  spi_mem_pkg::word_t     load_word,
    input  spi_mem_pkg::word_t     store_word,
    input  spi_mem_pkg::xfer_len_t store_len,
    input  spi_mem_pkg::word_t     instr_word,
    output spi_mem_pkg::spi_req_t  spi_req,
    output spi_mem_pkg::word_t     instr_data,
    output spi_mem_pkg::word_t     mem_rdata,
    output logic                   instr_ready,
    output logic                   mem_ready,
    output spi_mem_pkg::gpio_t     gpio_out
);

    spi_mem_pkg::access_state_t state;
    spi_mem_pkg::word_t next_data;
    spi_mem_pkg::spi_addr_t next_addr;
    logic next_valid;
    logic instr_ready_q;
    logic is_instr;
    logic pend_we;
    logic pend_re;
    logic legal_flag;
    logic flash_hit;
    logic psram_hit;
    logic gpio_hit;
    logic mem_hit;
    logic periph_strobe;
    logic data_req;
    logic same_addr;
    logic instr_req;

    // Sizes accepted for SPI memory: SB/SH/SW and LBU/LHU
    assign legal_flag = mem_flag[1:0] != 2'b11 && !(mem_flag[2] && mem_flag[1]);
    assign flash_hit = mem_addr[31:24] == `FLASH_REGION;
    assign psram_hit = mem_addr[31:24] == `PSRAM_REGION;
    assign gpio_hit = mem_addr[31:8] == `GPIO_PAGE;
    assign mem_hit = (flash_hit || psram_hit) && legal_flag;
    // GPIO and unmapped addresses answer in one cycle
    assign periph_strobe = (mem_we || mem_re) && !mem_hit;
    assign data_req = (mem_hit && (mem_we || mem_re)) || pend_we || pend_re;

    assign same_addr = instr_addr[`SPI_ADDR_W-1:0] == spi_req.addr;
    assign next_addr = spi_req.addr + `SPI_ADDR_W'(`INSTR_STEP);
    assign instr_req = !same_addr || !instr_ready_q;
    assign instr_ready = instr_ready_q && same_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= spi_mem_pkg::ACC_IDLE;
            spi_req <= '0;
            instr_data <= '0;
            next_data <= '0;
            next_valid <= 1'b0;
            instr_ready_q <= 1'b0;
            is_instr <= 1'b0;
            pend_we <= 1'b0;
            pend_re <= 1'b0;
            mem_rdata <= '0;
            mem_ready <= 1'b0;
            gpio_out <= '0;
        end else begin
            spi_req.start <= 1'b0;
            spi_req.stop <= 1'b0;
            spi_req.cont <= 1'b0;
            mem_ready <= 1'b0;

            if (periph_strobe) begin
                if (gpio_hit && mem_we) begin
                    gpio_out <= mem_wdata[`GPIO_W-1:0];
                end
                if (mem_re) begin
                    mem_rdata <= gpio_hit ? {{(32 - `GPIO_W){1'b0}}, gpio_out} : '0;
                end
                mem_ready <= 1'b1;
            end

            // Strobes last one cycle, keep them until the access starts
            if (mem_hit && (mem_we || mem_re)) begin
                pend_we <= mem_we;
                pend_re <= mem_re;
            end

            if (data_req && is_instr) begin
                spi_req.stop <= 1'b1;
                is_instr <= 1'b0;
                instr_ready_q <= 1'b0;
                next_valid <= 1'b0;
                state <= spi_mem_pkg::ACC_STOP;
            end else begin
                case (state)
                    spi_mem_pkg::ACC_IDLE: begin
                        if (data_req) begin
                            spi_req.start <= 1'b1;
                            spi_req.write <= mem_we || pend_we;
                            spi_req.chip <= flash_hit ? spi_mem_pkg::CHIP_FLASH
                                                      : spi_mem_pkg::CHIP_PSRAM;
                            spi_req.addr <= mem_addr[`SPI_ADDR_W-1:0];
                            spi_req.len <= store_len;
                            spi_req.wdata <= store_word;
                            pend_we <= 1'b0;
                            pend_re <= 1'b0;
                            instr_ready_q <= 1'b0;
                            state <= spi_mem_pkg::ACC_ACTIVE;
                        end else if (instr_req) begin
                            spi_req.start <= 1'b1;
                            spi_req.write <= 1'b0;
                            spi_req.chip <= spi_mem_pkg::CHIP_FLASH;
                            spi_req.addr <= instr_addr[`SPI_ADDR_W-1:0];
                            spi_req.len <= 6'd32;
                            spi_req.wdata <= '0;
                            is_instr <= 1'b1;
                            next_valid <= 1'b0;
                            instr_ready_q <= 1'b0;
                            state <= spi_mem_pkg::ACC_ACTIVE;
                        end
                    end
                    spi_mem_pkg::ACC_ACTIVE: begin
                        if (spi_rsp.done && is_instr) begin
                            instr_data <= instr_word;
                            instr_ready_q <= 1'b1;
                            spi_req.cont <= 1'b1;
                            state <= spi_mem_pkg::ACC_NEXT_INSTR;
                        end else if (spi_rsp.done) begin
                            if (!spi_req.write) begin
                                mem_rdata <= load_word;
                            end
                            mem_ready <= 1'b1;
                            spi_req.stop <= 1'b1;
                            state <= spi_mem_pkg::ACC_STOP;
                        end
                    end
                    spi_mem_pkg::ACC_NEXT_INSTR: begin
                        // A jump abandons the word being prefetched
                        if (!same_addr && instr_addr[`SPI_ADDR_W-1:0] != next_addr) begin
                            spi_req.stop <= 1'b1;
                            is_instr <= 1'b0;
                            instr_ready_q <= 1'b0;
                            state <= spi_mem_pkg::ACC_STOP;
                        end else if (spi_rsp.done) begin
                            next_data <= instr_word;
                            next_valid <= 1'b1;
                            state <= spi_mem_pkg::ACC_PAUSE;
                        end
                    end
                    spi_mem_pkg::ACC_PAUSE: begin
                        if (same_addr) begin
                            state <= spi_mem_pkg::ACC_PAUSE;
                        end else if (instr_addr[`SPI_ADDR_W-1:0] == next_addr && next_valid) begin
                            instr_data <= next_data;
                            instr_ready_q <= 1'b1;
                            spi_req.addr <= next_addr;
                            next_valid <= 1'b0;
                            spi_req.cont <= 1'b1;
                            state <= spi_mem_pkg::ACC_NEXT_INSTR;
                        end else begin
                            spi_req.stop <= 1'b1;
                            is_instr <= 1'b0;
                            instr_ready_q <= 1'b0;
                            next_valid <= 1'b0;
                            state <= spi_mem_pkg::ACC_STOP;
                        end
                    end
                    spi_mem_pkg::ACC_STOP: state <= spi_mem_pkg::ACC_IDLE;
                    default: state <= spi_mem_pkg::ACC_IDLE;
                endcase
            end
        end
    end

    ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |=> !mem_ready);

endmodule

//--- mem_ctl/spi_mem_ctl.sv
/*
 * SPI memory controller top level
 * Instruction fetch from flash, data access to PSRAM or flash,
 * GPIO output register, all over one serial SPI bus
 */
`timescale 1ns/100ps

module spi_mem_ctl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  spi_mem_pkg::word_t     instr_addr,
    output spi_mem_pkg::word_t     instr_data,
    output logic                   instr_ready,
    input  spi_mem_pkg::word_t     mem_addr,
    input  spi_mem_pkg::word_t     mem_wdata,
    input  spi_mem_pkg::mem_flag_t mem_flag,
    input  logic                   mem_we,
    input  logic                   mem_re,
    output spi_mem_pkg::word_t     mem_rdata,
    output logic                   mem_ready,
    output spi_mem_pkg::gpio_t     gpio_out,
    output logic                   flash_cs_n,
    output logic                   ram_cs_n,
    output logic                   spi_sclk,
    output logic                   spi_mosi,
    input  logic                   spi_miso
);

    spi_mem_pkg::spi_req_t spi_req;
    spi_mem_pkg::spi_rsp_t spi_rsp;
    spi_mem_pkg::word_t store_word;
    spi_mem_pkg::word_t load_word;
    spi_mem_pkg::word_t instr_word;
    spi_mem_pkg::xfer_len_t store_len;

    access_sequencer seq_i (
        .clk(clk), .rst_n(rst_n),
        .instr_addr(instr_addr), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_flag(mem_flag), .mem_we(mem_we), .mem_re(mem_re),
        .spi_rsp(spi_rsp), .load_word(load_word), .store_word(store_word),
        .store_len(store_len), .instr_word(instr_word),
        .spi_req(spi_req), .instr_data(instr_data), .mem_rdata(mem_rdata),
        .instr_ready(instr_ready), .mem_ready(mem_ready), .gpio_out(gpio_out)
    );

    load_store_format fmt_i (
        .mem_wdata(mem_wdata), .mem_flag(mem_flag), .wire_rdata(spi_rsp.rdata),
        .store_word(store_word), .store_len(store_len),
        .load_word(load_word), .instr_word(instr_word)
    );

    spi_master spi_i (
        .clk(clk), .rst_n(rst_n), .req(spi_req), .spi_miso(spi_miso), .rsp(spi_rsp),
        .flash_cs_n(flash_cs_n), .ram_cs_n(ram_cs_n),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi)
    );

endmodule

//--- spi_master/spi_master.sv
/*
 * Single-lane SPI master, mode 0, sclk at half the clock rate
 * Sends command and 24-bit address, then shifts len data bits out
 * and samples miso into the same register. The burst stays open in
 * HOLD until cont or stop.
 */
`timescale 1ns/100ps
`include "spi_mem_config.svh"

module spi_master (
    input  logic                  clk,
    input  logic                  rst_n,
    input  spi_mem_pkg::spi_req_t req,
    input  logic                  spi_miso,
    output spi_mem_pkg::spi_rsp_t rsp,
    output logic                  flash_cs_n,
    output logic                  ram_cs_n,
    output logic                  spi_sclk,
    output logic                  spi_mosi
);

    spi_mem_pkg::spi_phase_t phase;
    spi_mem_pkg::chip_sel_t chip_q;
    spi_mem_pkg::xfer_len_t len_q;
    logic [63:0] shreg;
    logic [5:0] bit_cnt;
    logic sclk_q;
    logic mosi_q;
    logic done_q;
    logic [7:0] cmd;
    logic last_bit;

    assign cmd = req.write ? `SPI_CMD_WRITE : `SPI_CMD_READ;
    assign last_bit = (bit_cnt == 6'd0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= spi_mem_pkg::PH_IDLE;
            chip_q <= spi_mem_pkg::CHIP_FLASH;
            len_q <= '0;
            shreg <= '0;
            bit_cnt <= '0;
            sclk_q <= 1'b0;
            mosi_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (req.stop) begin
                phase <= spi_mem_pkg::PH_IDLE;
                sclk_q <= 1'b0;
                mosi_q <= 1'b0;
            end else begin
                case (phase)
                    spi_mem_pkg::PH_IDLE: begin
                        if (req.start) begin
                            phase <= spi_mem_pkg::PH_CMD;
                            chip_q <= req.chip;
                            len_q <= req.len;
                            shreg <= {cmd, req.addr, req.wdata};
                            bit_cnt <= 6'd7;
                            mosi_q <= cmd[7];
                        end
                    end
                    spi_mem_pkg::PH_CMD, spi_mem_pkg::PH_ADDR, spi_mem_pkg::PH_DATA: begin
                        sclk_q <= !sclk_q;
                        if (!sclk_q) begin
                            // Rising edge: capture miso, advance the bit count
                            shreg <= {shreg[62:0], spi_miso};
                            if (!last_bit) begin
                                bit_cnt <= bit_cnt - 6'd1;
                            end else if (phase == spi_mem_pkg::PH_CMD) begin
                                phase <= spi_mem_pkg::PH_ADDR;
                                bit_cnt <= 6'(`SPI_ADDR_W - 1);
                            end else if (phase == spi_mem_pkg::PH_ADDR) begin
                                phase <= spi_mem_pkg::PH_DATA;
                                bit_cnt <= len_q - 6'd1;
                            end else begin
                                phase <= spi_mem_pkg::PH_HOLD;
                                done_q <= 1'b1;
                            end
                        end else begin
                            // Falling edge: present the next bit
                            mosi_q <= shreg[63];
                        end
                    end
                    spi_mem_pkg::PH_HOLD: begin
                        if (sclk_q) begin
                            sclk_q <= 1'b0;
                            mosi_q <= shreg[63];
                        end else if (req.cont) begin
                            phase <= spi_mem_pkg::PH_DATA;
                            bit_cnt <= req.len - 6'd1;
                        end
                    end
                    default: phase <= spi_mem_pkg::PH_IDLE;
                endcase
            end
        end
    end

    // Only the chip latched at start is selected
    assign flash_cs_n = !(phase != spi_mem_pkg::PH_IDLE && chip_q == spi_mem_pkg::CHIP_FLASH);
    assign ram_cs_n = !(phase != spi_mem_pkg::PH_IDLE && chip_q == spi_mem_pkg::CHIP_PSRAM);
    assign spi_sclk = sclk_q;
    assign spi_mosi = mosi_q;
    assign rsp.done = done_q;
    assign rsp.rdata = shreg[31:0];

    // A new burst needs the previous one stopped
    start_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
        req.start |-> phase == spi_mem_pkg::PH_IDLE);

    // More data only while the burst is held open
    cont_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        req.cont |-> phase == spi_mem_pkg::PH_HOLD);

endmodule

//--- spi_mem_ctl.f
+incdir+common
common/spi_mem_pkg.sv
logic/load_store_format.sv
spi_master/spi_master.sv
mem_ctl/access_sequencer.sv
mem_ctl/spi_mem_ctl.sv
testbench/clk_gen.sv
testbench/spi_mem_model.sv
testbench/tb_spi_mem_ctl.sv

//--- testbench/clk_gen.sv
/*
 * Clock and reset generator for the testbench
 */
`timescale 1ns/100ps

module clk_gen #(
    parameter int HALF_PERIOD = 10,
    parameter int RST_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = !clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- testbench/spi_mem_model.sv
/*
 * Behavioral serial memory, mode 0, commands 03h and 02h
 * Flash content follows a fixed pattern of the address, the writable
 * variant starts as zeros and accepts writes
 */
`timescale 1ns/100ps
`include "spi_mem_config.svh"

module spi_mem_model #(
    parameter bit writable = 1'b0
) (
    input  logic cs_n,
    input  logic sclk,
    input  logic mosi,
    output wire  miso
);

    bit [7:0] mem [int unsigned];
    logic [31:0] hdr;
    logic [23:0] base;
    logic [7:0] wshift;
    logic [7:0] rd_byte;
    logic is_write;
    logic miso_q;
    int unsigned cnt;

    initial begin
        cnt = 0;
        miso_q = 1'b0;
        is_write = 1'b0;
    end

    function automatic logic [7:0] read_byte(input logic [23:0] a);
        if (!writable) begin
            return 8'(a * 7 + 3);
        end
        return mem.exists(a) ? mem[a] : 8'h00;
    endfunction

    assign miso = cs_n ? 1'bz : miso_q;

    // Command and address first, then data bytes at rising sclk
    always @(posedge sclk or posedge cs_n) begin
        if (cs_n) begin
            cnt = 0;
            miso_q = 1'b0;
        end else if (cnt < 32) begin
            hdr = {hdr[30:0], mosi};
            if (cnt == 31) begin
                is_write = hdr[31:24] == `SPI_CMD_WRITE;
                base = hdr[23:0];
            end
            cnt = cnt + 1;
        end else begin
            wshift = {wshift[6:0], mosi};
            if (is_write && writable && ((cnt - 32) % 8 == 7)) begin
                mem[base + 24'((cnt - 32) / 8)] = wshift;
            end
            cnt = cnt + 1;
        end
    end

    // Read data changes after the falling edge
    always @(negedge sclk) begin
        if (!cs_n && cnt >= 32 && !is_write) begin
            rd_byte = read_byte(base + 24'((cnt - 32) / 8));
            miso_q = rd_byte[7 - ((cnt - 32) % 8)];
        end
    end

endmodule

//--- testbench/tb_spi_mem_ctl.sv
/*
 * Testbench for the SPI memory controller
 * Drives fetch, PSRAM, flash and GPIO traffic and checks the
 * responses with concurrent assertions against reference images
 */
`timescale 1ns/100ps
`include "spi_mem_config.svh"

module tb_spi_mem_ctl;

    logic clk;
    logic rst_n;
    spi_mem_pkg::word_t instr_addr;
    spi_mem_pkg::word_t instr_data;
    logic instr_ready;
    spi_mem_pkg::word_t mem_addr;
    spi_mem_pkg::word_t mem_wdata;
    spi_mem_pkg::mem_flag_t mem_flag;
    logic mem_we;
    logic mem_re;
    spi_mem_pkg::word_t mem_rdata;
    logic mem_ready;
    spi_mem_pkg::gpio_t gpio_out;
    logic flash_cs_n;
    logic ram_cs_n;
    logic spi_sclk;
    logic spi_mosi;
    wire spi_miso;

    logic data_busy;
    logic exp_check;
    spi_mem_pkg::word_t exp_rdata;
    logic [7:0] shadow [0:63];
    logic [31:0] lfsr;
    int cycle_cnt;
    int fail_count;

    pulldown (spi_miso);

    clk_gen clk_i (.clk(clk), .rst_n(rst_n));

    spi_mem_ctl dut_i (
        .clk(clk), .rst_n(rst_n),
        .instr_addr(instr_addr), .instr_data(instr_data), .instr_ready(instr_ready),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_flag(mem_flag),
        .mem_we(mem_we), .mem_re(mem_re), .mem_rdata(mem_rdata), .mem_ready(mem_ready),
        .gpio_out(gpio_out), .flash_cs_n(flash_cs_n), .ram_cs_n(ram_cs_n),
        .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso)
    );

    spi_mem_model #(.writable(1'b0)) flash_i (
        .cs_n(flash_cs_n), .sclk(spi_sclk), .mosi(spi_mosi), .miso(spi_miso)
    );

    spi_mem_model #(.writable(1'b1)) psram_i (
        .cs_n(ram_cs_n), .sclk(spi_sclk), .mosi(spi_mosi), .miso(spi_miso)
    );

    function automatic logic [7:0] flash_byte(input logic [23:0] a);
        return 8'(a * 7 + 3);
    endfunction

    // Little-endian word from the flash image
    function automatic spi_mem_pkg::word_t flash_word(input spi_mem_pkg::word_t a);
        logic [23:0] b;
        b = a[23:0];
        return {flash_byte(b + 3), flash_byte(b + 2), flash_byte(b + 1), flash_byte(b)};
    endfunction

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic report_mismatch(input string msg);
        fail_count++;
        $display("FAILED at %0t: %s", $time, msg);
        $display("Something failed");
        $fatal(1, "check failed");
    endtask

    task automatic wait_instr();
        @(negedge clk);
        while (!instr_ready) @(negedge clk);
    endtask

    task automatic set_pc(input spi_mem_pkg::word_t a);
        @(posedge clk);
        instr_addr <= a;
    endtask

    task automatic data_access(input logic we, input spi_mem_pkg::word_t addr,
                               input spi_mem_pkg::word_t wdata,
                               input spi_mem_pkg::mem_flag_t flag,
                               input logic chk, input spi_mem_pkg::word_t exp);
        @(posedge clk);
        mem_addr <= addr;
        mem_wdata <= wdata;
        mem_flag <= flag;
        mem_we <= we;
        mem_re <= !we;
        data_busy <= 1'b1;
        exp_check <= chk;
        exp_rdata <= exp;
        @(posedge clk);
        mem_we <= 1'b0;
        mem_re <= 1'b0;
        @(negedge clk);
        while (!mem_ready) @(negedge clk);
        @(posedge clk);
        data_busy <= 1'b0;
        exp_check <= 1'b0;
    endtask

    // Zero-extended value of the shadow image
    function automatic spi_mem_pkg::word_t shadow_load(input int off, input logic [1:0] sz);
        case (sz)
            2'd0: return {24'h0, shadow[off]};
            2'd1: return {16'h0, shadow[off + 1], shadow[off]};
            default: return {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
        endcase
    endfunction

    ifetch_data: assert property (@(posedge clk) disable iff (!rst_n)
        instr_ready |-> instr_data == flash_word(instr_addr))
        else report_mismatch("instr_data differs from flash image");
    ifetch_drop: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(instr_addr) |-> !instr_ready)
        else report_mismatch("instr_ready high after instr_addr changed");
    load_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready && exp_check |-> mem_rdata == exp_rdata)
        else report_mismatch("mem_rdata differs from expected load value");
    ready_expected: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ready |-> data_busy)
        else report_mismatch("mem_ready without outstanding request");
    data_first: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(instr_ready) |-> !$past(data_busy))
        else report_mismatch("fetch completed before pending data access");
    gpio_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_we || mem_re) && mem_addr[31:8] == `GPIO_PAGE |=> mem_ready)
        else report_mismatch("GPIO access not ready one cycle after strobe");
    gpio_value: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we && mem_addr[31:8] == `GPIO_PAGE |=> gpio_out == $past(mem_wdata[`GPIO_W-1:0]))
        else report_mismatch("gpio_out differs from written data");
    cs_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
        !(!flash_cs_n && !ram_cs_n))
        else report_mismatch("both chip selects low together");

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= 6000) begin
            $display("Timeout: the run did not finish within 6000 cycles");
            $display("Something failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wd;
        logic [1:0] ssz;
        logic [1:0] lsz;
        int off;
        instr_addr = '0;
        mem_addr = '0;
        mem_wdata = '0;
        mem_flag = '0;
        mem_we = 1'b0;
        mem_re = 1'b0;
        data_busy = 1'b0;
        exp_check = 1'b0;
        exp_rdata = '0;
        lfsr = 32'h9593_c4c4;
        cycle_cnt = 0;
        fail_count = 0;
        for (int i = 0; i < 64; i++) shadow[i] = 8'h00;
        @(posedge rst_n);

        // Sequential fetch through the prefetch path
        wait_instr();
        for (int i = 1; i < 6; i++) begin
            set_pc(i * `INSTR_STEP);
            wait_instr();
        end

        // Jump and continue
        set_pc(32'h0000_0140);
        wait_instr();
        set_pc(32'h0000_0144);
        wait_instr();

        // PSRAM stores and read-back
        for (int i = 0; i < 8; i++) begin
            random_bits(2, r);
            ssz = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
            random_bits(6, r);
            off = int'(r[5:0]) & ~((1 << ssz) - 1);
            random_bits(32, wd);
            for (int b = 0; b < (1 << ssz); b++) shadow[off + b] = wd[8 * b +: 8];
            data_access(1'b1, 32'h0100_0000 + off, wd, {1'b0, ssz}, 1'b0, '0);
            random_bits(2, r);
            lsz = (r[1:0] == 2'd3) ? 2'd2 : r[1:0];
            off = off & ~((1 << lsz) - 1);
            data_access(1'b0, 32'h0100_0000 + off, '0, {lsz != 2'd2, lsz},
                        1'b1, shadow_load(off, lsz));
        end

        // Load while a fetch burst is running
        set_pc(32'h0000_0200);
        @(negedge clk);
        while (flash_cs_n) @(negedge clk);
        repeat (20) @(negedge clk);
        data_access(1'b0, 32'h0100_0000, '0, 3'b010, 1'b1, shadow_load(0, 2'd2));
        wait_instr();
        set_pc(32'h0000_0204);
        wait_instr();

        // GPIO write and read-back
        random_bits(32, wd);
        data_access(1'b1, {`GPIO_PAGE, 8'h00}, wd, 3'b010, 1'b0, '0);
        data_access(1'b0, {`GPIO_PAGE, 8'h00}, '0, 3'b010, 1'b1,
                    {{(32 - `GPIO_W){1'b0}}, wd[`GPIO_W-1:0]});

        // Constant data from flash
        data_access(1'b0, 32'h0000_0313, '0, 3'b100, 1'b1, {24'h0, flash_byte(24'h313)});
        data_access(1'b0, 32'h0000_0420, '0, 3'b010, 1'b1, flash_word(32'h0000_0420));

        repeat (4) @(posedge clk);
        if (fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
